/* design/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction word
`define FETCH_INSTR_WIDTH 32

// cache geometry
`define FETCH_TAG_WIDTH 16
`define FETCH_ENTRIES 64
`define FETCH_BLOCK_WORDS 4

// word address is tag plus row plus word offset
`define FETCH_PC_WIDTH (`FETCH_TAG_WIDTH + $clog2(`FETCH_ENTRIES))

// one row holds one line
`define FETCH_ROWS (`FETCH_ENTRIES / `FETCH_BLOCK_WORDS)

// immediate widths, sign bit not counted
`define FETCH_BIMM_WIDTH 12
`define FETCH_JIMM_WIDTH 20

`endif

/* design/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

  // rv32 opcodes that transfer control
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;

  typedef logic [`FETCH_INSTR_WIDTH-1:0] instr_t;

  // byte-granular immediates, bit 0 always zero
  typedef logic [`FETCH_BIMM_WIDTH:0] bimm_t;
  typedef logic [`FETCH_JIMM_WIDTH:0] jimm_t;

  // one cache row
  typedef struct packed {
    logic [`FETCH_BLOCK_WORDS-1:0] lower_sign;
    logic [`FETCH_BLOCK_WORDS-1:0] lower_cout;
    logic [`FETCH_TAG_WIDTH-1:0] tag;
    logic [`FETCH_BLOCK_WORDS-1:0][`FETCH_INSTR_WIDTH-1:0] instr;
  } icache_entry_t;

  function automatic bimm_t bimm_extract(instr_t instr);
    return {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

  function automatic jimm_t jimm_extract(instr_t instr);
    return {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  // write bits [12:1] back into the scattered B fields
  function automatic instr_t bimm_inject(instr_t instr, bimm_t val);
    instr_t res;
    res = instr;
    res[31] = val[12];
    res[7] = val[11];
    res[30:25] = val[10:5];
    res[11:8] = val[4:1];
    return res;
  endfunction

  // write bits [20:1] back into the scattered J fields
  function automatic instr_t jimm_inject(instr_t instr, jimm_t val);
    instr_t res;
    res = instr;
    res[31] = val[20];
    res[19:12] = val[19:12];
    res[20] = val[11];
    res[30:21] = val[10:1];
    return res;
  endfunction

endpackage

/* design/icache_mem.sv */
`timescale 1ns/1ps

module icache_mem #(
  parameter int width_p = 8,
  parameter int els_p = 16,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic v_i,
  input  logic w_i,
  input  logic [addr_width_lp-1:0] addr_i,
  input  logic [width_p-1:0] w_mask_i,
  input  logic [width_p-1:0] data_i,
  output logic [width_p-1:0] data_o
);

  logic [width_p-1:0] mem [els_p];
  logic [width_p-1:0] data_r;

  // bit-granular write, untouched bits keep old contents
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      mem[addr_i] <= (mem[addr_i] & ~w_mask_i) | (data_i & w_mask_i);
    end
  end

  // read register only moves on a read, so output holds between reads
  always_ff @(posedge clk_i) begin
    if (v_i && !w_i) begin
      data_r <= mem[addr_i];
    end
  end

  assign data_o = data_r;

  // address in range on every access
  addr_in_range_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> (int'(addr_i) < els_p)
  ) else $error("icache_mem: address %0d out of range", addr_i);

endmodule

/* design/target_precompute.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module target_precompute (
  input  logic clk_i,
  input  logic reset_i,
  input  logic refill_v_i,
  input  logic [`FETCH_PC_WIDTH-1:0] refill_pc_i,
  input  logic [`FETCH_INSTR_WIDTH-1:0] refill_instr_i,
  output logic wr_v_o,
  output logic [$clog2(`FETCH_ROWS)-1:0] wr_row_o,
  output fetch_pkg::icache_entry_t wr_entry_o,
  output fetch_pkg::icache_entry_t wr_mask_o
);

  localparam int off_width_lp = $clog2(`FETCH_BLOCK_WORDS);
  localparam int row_width_lp = $clog2(`FETCH_ROWS);
  localparam int b_low_width_lp = `FETCH_BIMM_WIDTH + 1;
  localparam int j_low_width_lp = `FETCH_JIMM_WIDTH + 1;

  logic [`FETCH_TAG_WIDTH-1:0] w_tag;
  logic [row_width_lp-1:0] w_row;
  logic [off_width_lp-1:0] w_off;

  assign {w_tag, w_row, w_off} = refill_pc_i;

  logic [`FETCH_PC_WIDTH+1:0] byte_pc;
  assign byte_pc = {refill_pc_i, 2'b00};

  logic is_branch;
  logic is_jal;
  assign is_branch = (refill_instr_i[6:0] == fetch_pkg::OP_BRANCH);
  assign is_jal = (refill_instr_i[6:0] == fetch_pkg::OP_JAL);

  fetch_pkg::bimm_t b_imm;
  fetch_pkg::jimm_t j_imm;
  assign b_imm = fetch_pkg::bimm_extract(refill_instr_i);
  assign j_imm = fetch_pkg::jimm_extract(refill_instr_i);

  // low part of the target, carry kept for the read side
  fetch_pkg::bimm_t b_sum;
  fetch_pkg::jimm_t j_sum;
  logic b_cout;
  logic j_cout;

  assign {b_cout, b_sum} = {1'b0, b_imm} + {1'b0, byte_pc[b_low_width_lp-1:0]};
  assign {j_cout, j_sum} = {1'b0, j_imm} + {1'b0, byte_pc[j_low_width_lp-1:0]};

  fetch_pkg::instr_t injected;
  logic imm_sign;
  logic low_cout;

  always_comb begin
    if (is_branch) begin
      injected = fetch_pkg::bimm_inject(refill_instr_i, b_sum);
      imm_sign = b_imm[`FETCH_BIMM_WIDTH];
      low_cout = b_cout;
    end else if (is_jal) begin
      injected = fetch_pkg::jimm_inject(refill_instr_i, j_sum);
      imm_sign = j_imm[`FETCH_JIMM_WIDTH];
      low_cout = j_cout;
    end else begin
      // sign and carry are ignored for other opcodes
      injected = refill_instr_i;
      imm_sign = j_imm[`FETCH_JIMM_WIDTH];
      low_cout = j_cout;
    end
  end

  logic [`FETCH_BLOCK_WORDS-1:0] lane_sel;
  assign lane_sel = `FETCH_BLOCK_WORDS'(1) << w_off;

  fetch_pkg::icache_entry_t entry_n;
  fetch_pkg::icache_entry_t mask_n;

  // word goes to every lane, mask picks the one that lands
  always_comb begin
    entry_n.lower_sign = {`FETCH_BLOCK_WORDS{imm_sign}};
    entry_n.lower_cout = {`FETCH_BLOCK_WORDS{low_cout}};
    entry_n.tag = w_tag;
    entry_n.instr = {`FETCH_BLOCK_WORDS{injected}};
    mask_n.lower_sign = lane_sel;
    mask_n.lower_cout = lane_sel;
    mask_n.tag = '1;
    for (int i = 0; i < `FETCH_BLOCK_WORDS; i++) begin
      mask_n.instr[i] = {`FETCH_INSTR_WIDTH{lane_sel[i]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_v_o <= 1'b0;
    end else begin
      wr_v_o <= refill_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_v_i) begin
      wr_row_o <= w_row;
      wr_entry_o <= entry_n;
      wr_mask_o <= mask_n;
    end
  end

  // refill arrives as isolated strobes
  wr_single_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wr_v_o |=> !wr_v_o
  ) else $error("target_precompute: back-to-back refill writes");

endmodule

/* design/icache_array.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module icache_array (
  input  logic clk_i,
  input  logic reset_i,
  input  logic wr_v_i,
  input  logic [$clog2(`FETCH_ROWS)-1:0] wr_row_i,
  input  fetch_pkg::icache_entry_t wr_entry_i,
  input  fetch_pkg::icache_entry_t wr_mask_i,
  input  logic fetch_v_i,
  input  logic [`FETCH_PC_WIDTH-1:0] fetch_pc_i,
  output logic rd_v_o,
  output logic [`FETCH_PC_WIDTH-1:0] rd_pc_o,
  output logic [`FETCH_INSTR_WIDTH-1:0] rd_instr_o,
  output logic rd_sign_o,
  output logic rd_cout_o,
  output logic rd_hit_o
);

  localparam int off_width_lp = $clog2(`FETCH_BLOCK_WORDS);
  localparam int row_width_lp = $clog2(`FETCH_ROWS);
  localparam int entry_width_lp = $bits(fetch_pkg::icache_entry_t);

  // write owns the port, a colliding fetch is lost
  logic fetch_go;
  assign fetch_go = fetch_v_i && !wr_v_i;

  logic mem_v;
  logic [row_width_lp-1:0] mem_addr;
  logic [entry_width_lp-1:0] mem_data_lo;

  assign mem_v = wr_v_i || fetch_v_i;
  assign mem_addr = wr_v_i ? wr_row_i : fetch_pc_i[off_width_lp +: row_width_lp];

  icache_mem #(
    .width_p(entry_width_lp),
    .els_p(`FETCH_ROWS)
  ) mem (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(mem_v),
    .w_i(wr_v_i),
    .addr_i(mem_addr),
    .w_mask_i(wr_mask_i),
    .data_i(wr_entry_i),
    .data_o(mem_data_lo)
  );

  // pc register lines up with the sync read
  logic rd_v_r;
  logic [`FETCH_PC_WIDTH-1:0] rd_pc_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= 1'b0;
    end else begin
      rd_v_r <= fetch_go;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_go) begin
      rd_pc_r <= fetch_pc_i;
    end
  end

  fetch_pkg::icache_entry_t rd_entry;
  logic [off_width_lp-1:0] rd_lane;

  assign rd_entry = mem_data_lo;
  assign rd_lane = rd_pc_r[off_width_lp-1:0];

  assign rd_v_o = rd_v_r;
  assign rd_pc_o = rd_pc_r;
  assign rd_instr_o = rd_entry.instr[rd_lane];
  assign rd_sign_o = rd_entry.lower_sign[rd_lane];
  assign rd_cout_o = rd_entry.lower_cout[rd_lane];

  // tag sits at the top of the word address
  assign rd_hit_o = (rd_entry.tag == rd_pc_r[`FETCH_PC_WIDTH-1 -: `FETCH_TAG_WIDTH]);

endmodule

/* design/target_resolve.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module target_resolve (
  input  logic clk_i,
  input  logic reset_i,
  input  logic rd_v_i,
  input  logic [`FETCH_PC_WIDTH-1:0] rd_pc_i,
  input  logic [`FETCH_INSTR_WIDTH-1:0] rd_instr_i,
  input  logic rd_sign_i,
  input  logic rd_cout_i,
  input  logic rd_hit_i,
  input  logic [`FETCH_PC_WIDTH-1:0] jalr_pred_i,
  output logic out_v_o,
  output logic [`FETCH_INSTR_WIDTH-1:0] instr_o,
  output logic [`FETCH_PC_WIDTH-1:0] pc_o,
  output logic [`FETCH_PC_WIDTH-1:0] target_o,
  output logic miss_o
);

  localparam int byte_width_lp = `FETCH_PC_WIDTH + 2;
  localparam int b_low_width_lp = `FETCH_BIMM_WIDTH + 1;
  localparam int j_low_width_lp = `FETCH_JIMM_WIDTH + 1;
  localparam int b_high_width_lp = byte_width_lp - b_low_width_lp;
  localparam int j_high_width_lp = byte_width_lp - j_low_width_lp;

  logic [byte_width_lp-1:0] byte_pc;
  assign byte_pc = {rd_pc_i, 2'b00};

  logic [b_high_width_lp-1:0] b_high;
  logic [j_high_width_lp-1:0] j_high;
  assign b_high = byte_pc[byte_width_lp-1 -: b_high_width_lp];
  assign j_high = byte_pc[byte_width_lp-1 -: j_high_width_lp];

  // sign/cout 00 or 11 keep, 01 add one, 10 subtract one
  logic keep_high;
  logic inc_high;
  assign keep_high = ~(rd_sign_i ^ rd_cout_i);
  assign inc_high = ~rd_sign_i & rd_cout_i;

  logic [b_high_width_lp-1:0] b_high_adj;
  logic [j_high_width_lp-1:0] j_high_adj;

  always_comb begin
    if (keep_high) begin
      b_high_adj = b_high;
      j_high_adj = j_high;
    end else if (inc_high) begin
      b_high_adj = b_high + 1'b1;
      j_high_adj = j_high + 1'b1;
    end else begin
      b_high_adj = b_high - 1'b1;
      j_high_adj = j_high - 1'b1;
    end
  end

  // byte targets, low part already summed at refill
  logic [byte_width_lp-1:0] b_target;
  logic [byte_width_lp-1:0] j_target;
  assign b_target = {b_high_adj, fetch_pkg::bimm_extract(rd_instr_i)};
  assign j_target = {j_high_adj, fetch_pkg::jimm_extract(rd_instr_i)};

  logic [6:0] opcode;
  logic [`FETCH_PC_WIDTH-1:0] target_n;
  assign opcode = rd_instr_i[6:0];

  always_comb begin
    if (opcode == fetch_pkg::OP_JAL) begin
      target_n = j_target[2 +: `FETCH_PC_WIDTH];
    end else if (opcode == fetch_pkg::OP_JALR) begin
      target_n = jalr_pred_i;
    end else begin
      target_n = b_target[2 +: `FETCH_PC_WIDTH];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_v_o <= 1'b0;
    end else begin
      out_v_o <= rd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      instr_o <= rd_instr_i;
      pc_o <= rd_pc_i;
      target_o <= target_n;
      miss_o <= ~rd_hit_i;
    end
  end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic refill_v_i,
  input  logic [`FETCH_PC_WIDTH-1:0] refill_pc_i,
  input  logic [`FETCH_INSTR_WIDTH-1:0] refill_instr_i,
  input  logic fetch_v_i,
  input  logic [`FETCH_PC_WIDTH-1:0] fetch_pc_i,
  input  logic [`FETCH_PC_WIDTH-1:0] jalr_pred_i,
  output logic out_v_o,
  output logic [`FETCH_INSTR_WIDTH-1:0] instr_o,
  output logic [`FETCH_PC_WIDTH-1:0] pc_o,
  output logic [`FETCH_PC_WIDTH-1:0] target_o,
  output logic miss_o
);

  // refill side to array
  logic wr_v;
  logic [$clog2(`FETCH_ROWS)-1:0] wr_row;
  fetch_pkg::icache_entry_t wr_entry;
  fetch_pkg::icache_entry_t wr_mask;

  // array to resolve
  logic rd_v;
  logic [`FETCH_PC_WIDTH-1:0] rd_pc;
  logic [`FETCH_INSTR_WIDTH-1:0] rd_instr;
  logic rd_sign;
  logic rd_cout;
  logic rd_hit;

  target_precompute precompute (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .refill_v_i(refill_v_i),
    .refill_pc_i(refill_pc_i),
    .refill_instr_i(refill_instr_i),
    .wr_v_o(wr_v),
    .wr_row_o(wr_row),
    .wr_entry_o(wr_entry),
    .wr_mask_o(wr_mask)
  );

  icache_array array (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .wr_v_i(wr_v),
    .wr_row_i(wr_row),
    .wr_entry_i(wr_entry),
    .wr_mask_i(wr_mask),
    .fetch_v_i(fetch_v_i),
    .fetch_pc_i(fetch_pc_i),
    .rd_v_o(rd_v),
    .rd_pc_o(rd_pc),
    .rd_instr_o(rd_instr),
    .rd_sign_o(rd_sign),
    .rd_cout_o(rd_cout),
    .rd_hit_o(rd_hit)
  );

  target_resolve resolve (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rd_v_i(rd_v),
    .rd_pc_i(rd_pc),
    .rd_instr_i(rd_instr),
    .rd_sign_i(rd_sign),
    .rd_cout_i(rd_cout),
    .rd_hit_i(rd_hit),
    .jalr_pred_i(jalr_pred_i),
    .out_v_o(out_v_o),
    .instr_o(instr_o),
    .pc_o(pc_o),
    .target_o(target_o),
    .miss_o(miss_o)
  );

endmodule

/* tb/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;

  localparam int pc_width = `FETCH_PC_WIDTH;
  localparam int max_vectors = 64;

  logic clk_i = 1'b0;
  logic reset_i;
  logic refill_v_i;
  logic [pc_width-1:0] refill_pc_i;
  logic [`FETCH_INSTR_WIDTH-1:0] refill_instr_i;
  logic fetch_v_i;
  logic [pc_width-1:0] fetch_pc_i;
  logic [pc_width-1:0] jalr_pred_i = '0;
  logic out_v_o;
  logic [`FETCH_INSTR_WIDTH-1:0] instr_o;
  logic [pc_width-1:0] pc_o;
  logic [pc_width-1:0] target_o;
  logic miss_o;

  // one slot per vector line
  byte kind_mem [max_vectors];
  logic [31:0] pc_mem [max_vectors];
  logic [31:0] data_mem [max_vectors];
  logic [31:0] instr_mem [max_vectors];
  logic [31:0] target_mem [max_vectors];
  logic [31:0] miss_mem [max_vectors];
  int vec_count = 0;
  bit loaded = 1'b0;

  // fetches in flight, oldest first
  int idx_q [$];
  int issue_q [$];

  int cycle = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int other_errors = 0;
  int fetch_count = 0;
  logic [pc_width-1:0] fetch_pred = '0;
  logic [pc_width-1:0] pred_hold = '0;

  fetch_top uut (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .refill_v_i(refill_v_i),
    .refill_pc_i(refill_pc_i),
    .refill_instr_i(refill_instr_i),
    .fetch_v_i(fetch_v_i),
    .fetch_pc_i(fetch_pc_i),
    .jalr_pred_i(jalr_pred_i),
    .out_v_o(out_v_o),
    .instr_o(instr_o),
    .pc_o(pc_o),
    .target_o(target_o),
    .miss_o(miss_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // prediction trails its fetch by one cycle, in step with the array read
  always @(posedge clk_i) begin
    if (fetch_v_i) begin
      pred_hold = fetch_pred;
    end
    #1;
    jalr_pred_i = pred_hold;
  end

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    byte k;
    logic [31:0] pc;
    logic [31:0] data;
    logic [31:0] ei;
    logic [31:0] et;
    logic [31:0] em;
    fd = $fopen("tb/fetch_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/fetch_testdata.txt");
      return;
    end
    while (!$feof(fd) && vec_count < max_vectors) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h", k, pc, data, ei, et, em);
        if (n == 6 && (k == "R" || k == "F" || k == "N" || k == "M")) begin
          kind_mem[vec_count] = k;
          pc_mem[vec_count] = pc;
          data_mem[vec_count] = data;
          instr_mem[vec_count] = ei;
          target_mem[vec_count] = et;
          miss_mem[vec_count] = em;
          vec_count++;
        end else if (n > 0) begin
          $display("unreadable vector line: %s", line);
          other_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
  endtask

  task automatic drive_refill(input int idx);
    refill_v_i = 1'b1;
    refill_pc_i = pc_mem[idx][pc_width-1:0];
    refill_instr_i = data_mem[idx];
    @(posedge clk_i);
    #1;
    refill_v_i = 1'b0;
    // idle cycle so the write lands before the next fetch
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_fetch(input int idx);
    fetch_v_i = 1'b1;
    fetch_pc_i = pc_mem[idx][pc_width-1:0];
    fetch_pred = data_mem[idx][pc_width-1:0];
    idx_q.push_back(idx);
    issue_q.push_back(cycle);
    fetch_count++;
    @(posedge clk_i);
    #1;
    fetch_v_i = 1'b0;
  endtask

  task automatic run_vectors();
    int gap;
    bit prev_refill;
    bit is_refill;
    prev_refill = 1'b1;
    for (int i = 0; i < vec_count; i++) begin
      is_refill = (kind_mem[i] == "R");
      // random idle gap where refill and fetch groups meet
      if (i > 0 && is_refill != prev_refill) begin
        gap = $urandom % 4;
        repeat (gap) begin
          @(posedge clk_i);
          #1;
        end
      end
      if (is_refill) begin
        drive_refill(i);
      end else begin
        drive_fetch(i);
      end
      prev_refill = is_refill;
    end
  endtask

  task automatic check_output();
    int idx;
    int issued;
    bit ok;
    if (idx_q.size() == 0) begin
      $display("out_v_o high at time %0t with no fetch outstanding", $time);
      other_errors++;
    end else begin
      idx = idx_q.pop_front();
      issued = issue_q.pop_front();
      ok = 1'b1;
      if (cycle != issued + 2) begin
        $display("output at time %0t came %0d cycles after its fetch instead of 2",
                 $time, cycle - issued);
        ok = 1'b0;
      end
      if (pc_o !== pc_mem[idx][pc_width-1:0]) begin
        show_mismatch("pc_o", pc_mem[idx], 32'(pc_o));
        ok = 1'b0;
      end
      if (miss_o !== miss_mem[idx][0]) begin
        show_mismatch("miss_o", miss_mem[idx], 32'(miss_o));
        ok = 1'b0;
      end
      if (kind_mem[idx] != "M" && instr_o !== instr_mem[idx]) begin
        show_mismatch("instr_o", instr_mem[idx], instr_o);
        ok = 1'b0;
      end
      if (kind_mem[idx] == "F" && target_o !== target_mem[idx][pc_width-1:0]) begin
        show_mismatch("target_o", target_mem[idx], 32'(target_o));
        ok = 1'b0;
      end
      tests_run++;
      if (ok) begin
        $display("test %0d kind %c pc %h passed", tests_run, kind_mem[idx], pc_mem[idx]);
      end else begin
        $display("test %0d kind %c pc %h failed", tests_run, kind_mem[idx], pc_mem[idx]);
        tests_failed++;
      end
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (reset_i == 1'b0 && out_v_o === 1'b1) begin
      check_output();
    end
  end

  initial begin
    wait (loaded);
    repeat (vec_count * 20) @(posedge clk_i);
    $display("watchdog expired with %0d fetches still outstanding", idx_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reset_i = 1'b1;
    refill_v_i = 1'b0;
    refill_pc_i = '0;
    refill_instr_i = '0;
    fetch_v_i = 1'b0;
    fetch_pc_i = '0;
    void'($urandom(14183));
    load_vectors();
    if (vec_count == 0) begin
      $display("no vectors loaded from tb/fetch_testdata.txt");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (4) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      run_vectors();
      while (idx_q.size() > 0) begin
        @(posedge clk_i);
      end
      repeat (3) @(posedge clk_i);
      $display("%0d tests run, %0d passed, %0d failed, %0d other errors",
               tests_run, tests_run - tests_failed, tests_failed, other_errors);
      if (tests_failed == 0 && other_errors == 0 && tests_run == fetch_count) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

/* fetch_top.f */
+incdir+design
design/fetch_pkg.sv
design/icache_mem.sv
design/target_precompute.sv
design/icache_array.sv
design/target_resolve.sv
design/fetch_top.sv
tb/fetch_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := fetch_top.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/fetch_testdata.txt */
# kind pc data exp_instr exp_target exp_miss, all hex, pc and target are word addresses
# kind R refill, F fetch full check, N fetch without target check, M fetch expecting a miss
# refills, one per row
R 00001C 00500093 0 0 0
R 17FC00 000020EF 0 0 0
R 100044 E01FF06F 0 0 0
R 0287C9 20208063 0 0 0
R 04900D 804190E3 0 0 0
R 000112 0062C863 0 0 0
R 000515 FC8380E3 0 0 0
R 00015A 00008067 0 0 0
# plain word, then jal carry and borrow
N 00001C 0 00500093 0 0
F 17FC00 0 000010EF 180400 0
F 100044 0 F11FF06F 0FFFC4 0
# branches: forward carry, backward borrow, no carry, backward keep
F 0287C9 0 12208263 028849 0
F 04900D 0 82419AE3 048E0D 0
F 000112 0 4462CC63 000116 0
F 000515 0 C0838A63 000505 0
# jalr takes the prediction
F 00015A 2ABCDE 00008067 2ABCDE 0
# tag mismatches
M 00005C 0 0 0 1
M 000000 0 0 0 1
# new tag into row 7 replaces the old one
R 00005D 00700113 0 0 0
N 00005D 0 00700113 0 0
M 00001C 0 0 0 1
F 00015A 1234AB 00008067 1234AB 0
F 17FC00 0 000010EF 180400 0
